//--- neuron_pkg.sv
// Neuron engine shared definitions
`default_nettype none

package neuron_pkg;

  // Datapath sizing
  localparam int NEURON_WIDTH  = 8;                  // Neuron values and coefficients
  localparam int ACC_WIDTH     = 20;                 // Accumulator and result
  localparam int NUM_INPUTS    = 8;                  // Neurons per vector
  localparam int COEFF_DEPTH   = NUM_INPUTS + 1;     // Bias at index 0, weights after it
  localparam int OPERAND_WIDTH = NEURON_WIDTH + 1;   // Room for an unsigned neuron as signed
  localparam int PROD_WIDTH    = 2 * OPERAND_WIDTH;

  // Coefficient in two's complement
  typedef logic [NEURON_WIDTH-1:0] coeff_t;

  // Neuron value, its sign flag decides how it is read
  typedef logic [NEURON_WIDTH-1:0] neuron_t;

  typedef logic signed [ACC_WIDTH-1:0] acc_t;  // Accumulator and result word

  // Index into the coefficient store
  typedef logic [3:0] coeff_idx_t;

  // Saturation limits of the accumulator
  localparam acc_t ACC_MAX = acc_t'((2 ** (ACC_WIDTH - 1)) - 1);
  localparam acc_t ACC_MIN = acc_t'(-(2 ** (ACC_WIDTH - 1)));

  // Instruction given to the ALU
  typedef enum logic [1:0] {
    HALT = 2'b00,  // Clear the accumulator
    LOAD = 2'b01,  // Accumulator takes the coefficient
    MAC  = 2'b10,  // Accumulate coefficient times neuron
    NOP  = 2'b11   // Keep the accumulator
  } opcode_e;

  // Sequencer states, one pass per vector
  typedef enum logic [2:0] {
    S_IDLE   = 3'd0,
    S_LOAD   = 3'd1,
    S_MAC    = 3'd2,
    S_RESULT = 3'd3,
    S_CLEAR  = 3'd4
  } seq_state_e;

endpackage

`default_nettype wire

//--- mac_if.sv
// MAC instruction slot
`timescale 1ns/100ps
`default_nettype none

interface mac_if
  import neuron_pkg::*;
();

  logic    hold;         // ALU keeps its accumulator while high
  opcode_e opcode;
  logic    neuron_en;    // Low clears the accumulator on an unheld cycle
  coeff_t  coeff;        // Coefficient read from the store
  neuron_t neuron;
  logic    neuron_sign;  // Neuron is signed when set

  // Control side issues one instruction per cycle
  modport sequencer (
    output hold,
    output opcode,
    output neuron_en,
    output coeff,
    output neuron,
    output neuron_sign
  );

  modport alu (
    input hold,
    input opcode,
    input neuron_en,
    input coeff,
    input neuron,
    input neuron_sign
  );

endinterface

`default_nettype wire

//--- neuron_alu.sv
// Signed MAC unit
`timescale 1ns/100ps
`default_nettype none

module neuron_alu
  import neuron_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,
  mac_if.alu    mac,
  output acc_t  acc
);

  logic signed [OPERAND_WIDTH-1:0] opa;      // Coefficient operand
  logic signed [OPERAND_WIDTH-1:0] opb;      // Neuron operand
  logic signed [PROD_WIDTH-1:0]    product;
  logic signed [ACC_WIDTH:0]       sum_raw;  // One guard bit for overflow detection
  acc_t                            sum_sat;

  // Operands, products and the saturated sum
  always_comb begin
    opa = $signed({mac.coeff[NEURON_WIDTH-1], mac.coeff});

    // An unsigned neuron gets a zero on top so 0xFF stays 255
    if (mac.neuron_sign) begin
      opb = $signed({mac.neuron[NEURON_WIDTH-1], mac.neuron});
    end else begin
      opb = $signed({1'b0, mac.neuron});
    end

    product = opa * opb;
    sum_raw = (ACC_WIDTH + 1)'(product) + (ACC_WIDTH + 1)'(acc);

    // The top two bits disagree only when the sum left the 20-bit range
    case (sum_raw[ACC_WIDTH:ACC_WIDTH-1])
      2'b01:   sum_sat = ACC_MAX;
      2'b10:   sum_sat = ACC_MIN;
      default: sum_sat = sum_raw[ACC_WIDTH-1:0];
    endcase
  end

  // Accumulator register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (!mac.hold) begin
      if (!mac.neuron_en) begin
        acc <= '0;
      end else begin
        case (mac.opcode)
          HALT: acc <= '0;
          LOAD: acc <= {{(ACC_WIDTH-NEURON_WIDTH){mac.coeff[NEURON_WIDTH-1]}}, mac.coeff};
          MAC:  acc <= sum_sat;
          default: acc <= acc;  // NOP
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- coeff_store.sv
// Bias and weight store
`timescale 1ns/100ps
`default_nettype none

module coeff_store
  import neuron_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        cfg_valid,
  output logic       cfg_ready,
  input  coeff_idx_t cfg_idx,
  input  coeff_t     cfg_data,
  input  coeff_idx_t rd_idx,
  output coeff_t     rd_data
);

  coeff_t mem [COEFF_DEPTH];  // Index 0 is the bias
  logic   cfg_xfer;
  logic   wr_in_range;

  assign cfg_ready   = 1'b1;  // A write never stalls
  assign cfg_xfer    = cfg_valid & cfg_ready;
  assign wr_in_range = (cfg_idx < coeff_idx_t'(COEFF_DEPTH));

  // Writes land on the transfer edge, so reads see them one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < COEFF_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (cfg_xfer && wr_in_range) begin
      mem[cfg_idx] <= cfg_data;
    end
  end

  // Asynchronous read
  always_comb begin
    if (rd_idx < coeff_idx_t'(COEFF_DEPTH)) begin
      rd_data = mem[rd_idx];
    end else begin
      rd_data = '0;  // Out-of-range index reads as zero
    end
  end

endmodule

`default_nettype wire

//--- neuron_sequencer.sv
// Vector control sequencer
`timescale 1ns/100ps
`default_nettype none

module neuron_sequencer
  import neuron_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         in_valid,
  output logic        in_ready,
  input  neuron_t     in_neuron,
  input  wire         in_sign,
  output logic        res_valid,
  input  wire         res_ready,
  output acc_t        res_data,
  input  acc_t        acc,
  output coeff_idx_t  rd_idx,
  input  coeff_t      rd_data,
  mac_if.sequencer    mac
);

  seq_state_e state;
  seq_state_e state_next;
  coeff_idx_t cnt;       // Weight index of the next neuron, 1 to NUM_INPUTS
  logic       in_xfer;
  logic       res_xfer;
  logic       last_in;   // The accepted neuron closes the vector

  assign in_ready  = (state == S_MAC);
  assign res_valid = (state == S_RESULT);  // Up one cycle after the last input transfer
  assign res_data  = acc;                  // Held while the ALU is held in S_RESULT

  assign in_xfer  = in_valid & in_ready;
  assign res_xfer = res_valid & res_ready;
  assign last_in  = (cnt == coeff_idx_t'(NUM_INPUTS));

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      S_IDLE:   state_next = S_LOAD;
      S_LOAD:   state_next = S_MAC;
      S_MAC: begin
        if (in_xfer && last_in) begin
          state_next = S_RESULT;
        end
      end
      S_RESULT: begin
        if (res_xfer) begin
          state_next = S_CLEAR;
        end
      end
      S_CLEAR:  state_next = S_LOAD;
      default:  state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Neuron counter, restarted by every LOAD
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (state == S_LOAD) begin
      cnt <= coeff_idx_t'(1);
    end else if (in_xfer && !last_in) begin
      cnt <= cnt + coeff_idx_t'(1);
    end
  end

  // Store index follows the instruction in flight
  always_comb begin
    if (state == S_LOAD) begin
      rd_idx = '0;  // Bias
    end else begin
      rd_idx = cnt;
    end
  end

  // Instruction slot
  always_comb begin
    mac.coeff       = rd_data;    // Routed from the store
    mac.neuron      = in_neuron;
    mac.neuron_sign = in_sign;
    mac.neuron_en   = 1'b1;
    mac.hold        = 1'b1;
    mac.opcode      = NOP;
    case (state)
      S_IDLE: begin
        mac.neuron_en = 1'b0;
      end
      S_LOAD: begin
        mac.opcode = LOAD;
        mac.hold   = 1'b0;
      end
      S_MAC: begin
        mac.opcode = MAC;
        mac.hold   = ~in_xfer;  // A starved cycle leaves the accumulator alone
      end
      S_CLEAR: begin
        mac.opcode = HALT;
        mac.hold   = 1'b0;
      end
      default: begin
        // S_RESULT keeps the accumulator until the result is taken
        mac.opcode = NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- neuron_engine_top.sv
// Neuron scoring engine
`timescale 1ns/100ps
`default_nettype none

module neuron_engine_top
  import neuron_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // Coefficient write port
  input  wire        cfg_valid,
  output logic       cfg_ready,
  input  coeff_idx_t cfg_idx,
  input  coeff_t     cfg_data,
  // Neuron input
  input  wire        in_valid,
  output logic       in_ready,
  input  neuron_t    in_neuron,
  input  wire        in_sign,
  // Result
  output logic       res_valid,
  input  wire        res_ready,
  output acc_t       res_data
);

  acc_t       acc;
  coeff_idx_t rd_idx;
  coeff_t     rd_data;

  mac_if i_mac ();  // Instruction slot from sequencer to ALU

  neuron_sequencer i_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_neuron (in_neuron),
    .in_sign   (in_sign),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .acc       (acc),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .mac       (i_mac.sequencer)
  );

  coeff_store i_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg_idx   (cfg_idx),
    .cfg_data  (cfg_data),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data)
  );

  neuron_alu i_alu (
    .clk   (clk),
    .rst_n (rst_n),
    .mac   (i_mac.alu),
    .acc   (acc)
  );

endmodule

`default_nettype wire

//--- neuron_engine_properties.sv
// Neuron engine handshake checks
`timescale 1ns/100ps
`default_nettype none

module neuron_engine_properties
  import neuron_pkg::*;
(
  input wire  clk,
  input wire  rst_n,
  input wire  cfg_valid,
  input wire  cfg_ready,
  input wire  in_valid,
  input wire  in_ready,
  input wire  res_valid,
  input wire  res_ready,
  input acc_t res_data
);

  logic vec_busy;  // From the first neuron of a vector until its result is taken

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vec_busy <= 1'b0;
    end else if (res_valid && res_ready) begin
      vec_busy <= 1'b0;
    end else if (in_valid && in_ready) begin
      vec_busy <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !in_ready && !res_valid)
    else $error("in_ready or res_valid high during reset");

  a_result_held: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_data))
    else $error("result dropped or changed before it was taken");

  a_one_side: assert property (@(posedge clk) disable iff (!rst_n) !(in_ready && res_valid))
    else $error("in_ready and res_valid high together");

  // Coefficients only change between vectors
  a_cfg_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_valid && cfg_ready |-> !vec_busy && !res_valid)
    else $error("coefficient written while a vector is in progress");

endmodule

`default_nettype wire

//--- tb_neuron_engine.sv
// Neuron engine testbench
`timescale 1ns/100ps
`default_nettype none

module tb_neuron_engine
  import neuron_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 4000;  // About 60 vectors with coefficient flushes, plus margin

  logic       clk = 1'b0;
  logic       rst_n;
  logic       cfg_valid;
  logic       cfg_ready;
  coeff_idx_t cfg_idx;
  coeff_t     cfg_data;
  logic       in_valid;
  logic       in_ready;
  neuron_t    in_neuron;
  logic       in_sign;
  logic       res_valid;
  logic       res_ready;
  acc_t       res_data;

  coeff_t  coeff_model [COEFF_DEPTH];  // Coefficients the DUT currently uses
  coeff_t  pend [COEFF_DEPTH];         // Next coefficient set to program
  neuron_t vec_n [NUM_INPUTS];
  logic    vec_s [NUM_INPUTS];
  int      err_count = 0;
  int      check_count = 0;
  int      test_count = 0;
  int      cycle_cnt;

  always #4 clk = ~clk;

  neuron_engine_top i_dut (.*);

  bind neuron_engine_top neuron_engine_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

  task automatic compare_acc(input acc_t got, input acc_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Stepwise reference: bias first, then each product added and clamped
  function automatic acc_t model_score();
    int sum;
    int op;
    int hi;
    int lo;
    hi  = (1 << (ACC_WIDTH - 1)) - 1;
    lo  = -(1 << (ACC_WIDTH - 1));
    sum = int'($signed(coeff_model[0]));
    for (int k = 0; k < NUM_INPUTS; k++) begin
      op  = vec_s[k] ? int'($signed(vec_n[k])) : int'(vec_n[k]);
      sum += int'($signed(coeff_model[k + 1])) * op;
      if (sum > hi) sum = hi;
      if (sum < lo) sum = lo;
    end
    return acc_t'(sum);
  endfunction

  // All driving tasks start and end just after a falling edge
  task automatic write_coeff(input coeff_idx_t idx, input coeff_t data);
    cfg_valid = 1'b1;
    cfg_idx   = idx;
    cfg_data  = data;
    compare_flag(cfg_ready, 1'b1, "cfg_ready");  // The store never stalls a write
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic send_neuron(input neuron_t n, input logic s);
    in_valid  = 1'b1;
    in_neuron = n;
    in_sign   = s;
    while (!in_ready) @(negedge clk);
    @(negedge clk);  // Transfer took place on the rising edge in between
    in_valid = 1'b0;
  endtask

  task automatic take_result(output acc_t got);
    res_ready = 1'b1;
    while (!res_valid) @(negedge clk);
    got = res_data;
    @(negedge clk);
    res_ready = 1'b0;
  endtask

  // The waiting vector already holds the old bias, so a zero vector flushes it
  task automatic program_coeffs();
    acc_t got;
    acc_t old_bias;
    old_bias = acc_t'($signed(coeff_model[0]));
    while (!in_ready) @(negedge clk);
    for (int i = 0; i < COEFF_DEPTH; i++) write_coeff(coeff_idx_t'(i), pend[i]);
    for (int k = 0; k < NUM_INPUTS; k++) send_neuron(neuron_t'(0), 1'b0);
    take_result(got);
    compare_acc(got, old_bias, "flush result");
    coeff_model = pend;
  endtask

  task automatic randomize_vector();
    for (int k = 0; k < NUM_INPUTS; k++) begin
      vec_n[k] = neuron_t'($urandom());
      vec_s[k] = 1'($urandom());
    end
  endtask

  task automatic run_vector(input int gap_max, input int stall, output acc_t got);
    acc_t exp;
    acc_t held;
    int   gap;
    exp = model_score();
    for (int k = 0; k < NUM_INPUTS; k++) begin
      gap = int'($urandom_range(gap_max, 0));
      repeat (gap) @(negedge clk);
      send_neuron(vec_n[k], vec_s[k]);
    end
    compare_flag(res_valid, 1'b1, "res_valid one cycle after the last neuron");
    held = res_data;
    repeat (stall) begin
      @(negedge clk);
      compare_flag(in_ready, 1'b0, "in_ready under back-pressure");
      compare_acc(res_data, held, "res_data under back-pressure");
    end
    take_result(got);
    compare_acc(got, exp, "result");
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) $display("%s: ok at %0d ns", name, $time);
    else $display("%s: %0d errors at %0d ns", name, err_count - errs_before, $time);
  endtask

  task automatic reset_and_zero_result();
    int   errs;
    acc_t got;
    errs  = err_count;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      compare_flag(in_ready, 1'b0, "in_ready in reset");
      compare_flag(res_valid, 1'b0, "res_valid in reset");
    end
    rst_n = 1'b1;
    randomize_vector();
    run_vector(0, 0, got);
    compare_acc(got, '0, "first result with cleared store");
    report_test("reset state", errs);
  endtask

  task automatic mixed_sign_vectors();
    int   errs;
    acc_t got;
    errs = err_count;
    pend = '{8'h0a, 8'h03, 8'hfe, 8'h05, 8'h7f, 8'h80, 8'h01, 8'hff, 8'h07};
    program_coeffs();
    vec_n = '{8'hff, 8'hff, 8'h10, 8'h80, 8'h80, 8'h01, 8'h7f, 8'hfe};
    vec_s = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    run_vector(0, 0, got);
    vec_n = '{8'hff, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
    run_vector(0, 0, got);
    compare_acc(got, acc_t'(7), "signed 0xff as -1");
    vec_s[0] = 1'b0;
    run_vector(0, 0, got);
    compare_acc(got, acc_t'(775), "unsigned 0xff as 255");
    report_test("signed and unsigned operands", errs);
  endtask

  // Eight terms stay just inside the 20-bit range at both extremes
  task automatic saturation_extremes();
    int   errs;
    acc_t got;
    errs = err_count;
    foreach (pend[i]) pend[i] = 8'h7f;
    foreach (vec_n[k]) vec_n[k] = 8'hff;
    foreach (vec_s[k]) vec_s[k] = 1'b0;
    program_coeffs();
    run_vector(0, 0, got);
    compare_acc(got, acc_t'(259207), "largest positive sum");
    foreach (pend[i]) pend[i] = 8'h80;
    program_coeffs();
    run_vector(0, 0, got);
    compare_acc(got, acc_t'(-261248), "largest negative sum");
    report_test("saturation extremes", errs);
  endtask

  task automatic result_backpressure();
    int   errs;
    acc_t got;
    errs = err_count;
    randomize_vector();
    run_vector(0, 6, got);
    randomize_vector();
    run_vector(1, 3, got);
    report_test("result back-pressure", errs);
  endtask

  // Same vector back to back, and the accumulator reads zero between HALT and LOAD
  task automatic input_gaps_and_clear();
    int   errs;
    acc_t got;
    errs = err_count;
    foreach (pend[i]) pend[i] = coeff_t'($urandom());
    program_coeffs();
    randomize_vector();
    repeat (4) begin
      run_vector(3, 0, got);
      @(negedge clk);  // HALT has cleared the accumulator, LOAD comes next
      compare_acc(res_data, '0, "accumulator after HALT");
    end
    report_test("input gaps and clear", errs);
  endtask

  task automatic random_vectors();
    int   errs;
    acc_t got;
    errs = err_count;
    repeat (20) begin
      foreach (pend[i]) pend[i] = coeff_t'($urandom());
      program_coeffs();
      randomize_vector();
      run_vector(1, 0, got);
    end
    report_test("random vectors", errs);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'hd8f63cab));
    rst_n     = 1'b0;
    cfg_valid = 1'b0;
    cfg_idx   = '0;
    cfg_data  = '0;
    in_valid  = 1'b0;
    in_neuron = '0;
    in_sign   = 1'b0;
    res_ready = 1'b0;
    foreach (coeff_model[i]) coeff_model[i] = '0;
    reset_and_zero_result();
    mixed_sign_vectors();
    saturation_extremes();
    result_backpressure();
    input_gaps_and_clear();
    random_vectors();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- neuron_engine.f
neuron_pkg.sv
mac_if.sv
neuron_alu.sv
coeff_store.sv
neuron_sequencer.sv
neuron_engine_top.sv
neuron_engine_properties.sv
tb_neuron_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the neuron engine simulation with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_neuron_engine -f neuron_engine.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vtb_neuron_engine 2>&1)"
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
